// File: cpu_top.f
+incdir+logic
logic/cpu_isa_pkg.sv
logic/cpu_pipe_pkg.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/cpu_top.sv
testbench/cpu_top_assertions.sv
testbench/cpu_top_tb.sv

// File: Bender.yml
package:
  name: cpu_top

export_include_dirs:
  - logic

sources:
  - files:
      - logic/cpu_isa_pkg.sv
      - logic/cpu_pipe_pkg.sv
      - logic/decode_stage.sv
      - logic/reg_file.sv
      - logic/exec_stage.sv
      - logic/mem_stage.sv
      - logic/cpu_top.sv
  - target: test
    files:
      - testbench/cpu_top_assertions.sv
      - testbench/cpu_top_tb.sv

// File: testbench/cpu_top_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module cpu_top_tb;

  import cpu_isa_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int N_INST     = 80; // Upper bound on instructions issued by all tests

  logic                     clk;
  logic                     reset;
  logic                     inst_valid;
  inst_t                    inst;
  logic [`CPU_KEYBITS-1:0]  key;
  logic [`CPU_SWBITS-1:0]   sw;
  logic [`CPU_HEXBITS-1:0]  hex_value;
  logic [`CPU_LEDRBITS-1:0] ledr;

  // Reference model state
  word_t                    m_regs [16];
  word_t                    m_mem [`CPU_DMEM_WORDS];
  logic [`CPU_HEXBITS-1:0]  m_hex;
  logic [`CPU_LEDRBITS-1:0] m_ledr;

  integer seed = 32'h6c3b;
  int     checks = 0;
  int     errors = 0;
  int     t_checks;
  int     t_errors;

  op1_t imm_ops [4]  = '{OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};
  op2_t alu_ops [12] = '{OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND,
                         OP2_OR, OP2_XOR, OP2_SUB, OP2_NXOR, OP2_RSHF, OP2_LSHF};

  cpu_top UUT (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .key        (key),
    .sw         (sw),
    .hex_value  (hex_value),
    .ledr       (ledr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(N_INST * 8 * CLK_PERIOD + 200 * CLK_PERIOD);
    $display("Watchdog expired, the tests did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [15:0] rand16();
    return 16'($random(seed));
  endfunction

  function automatic word_t sext(input logic [`CPU_IMMBITS-1:0] imm);
    return {{(`CPU_DBITS-`CPU_IMMBITS){imm[`CPU_IMMBITS-1]}}, imm};
  endfunction

  function automatic inst_t i_inst(input op1_t op, input logic [15:0] imm,
                                   input regno_t rs, input regno_t rt);
    inst_t x;
    x       = '0;
    x.i.op1 = op;
    x.i.imm = imm;
    x.i.rs  = rs;
    x.i.rt  = rt;
    return x;
  endfunction

  function automatic inst_t r_inst(input logic [7:0] op2, input regno_t rd,
                                   input regno_t rs, input regno_t rt);
    inst_t x;
    x       = '0;
    x.r.op1 = OP1_ALUR;
    x.r.op2 = op2_t'(op2);
    x.r.rd  = rd;
    x.r.rs  = rs;
    x.r.rt  = rt;
    return x;
  endfunction

  function automatic word_t load_ref(input word_t addr);
    if (addr == `CPU_ADDR_KEY)
      return {{(`CPU_DBITS-`CPU_KEYBITS){1'b0}}, ~key}; // Keys read inverted
    if (addr == `CPU_ADDR_SW)
      return {{(`CPU_DBITS-`CPU_SWBITS){1'b0}}, sw};
    return m_mem[addr[9:2]];
  endfunction

  task automatic store_ref(input word_t addr, input word_t data);
    if (addr == `CPU_ADDR_HEX)
      m_hex = data[`CPU_HEXBITS-1:0];
    else if (addr == `CPU_ADDR_LEDR)
      m_ledr = data[`CPU_LEDRBITS-1:0];
    else
      m_mem[addr[9:2]] = data;
  endtask

  task automatic model_apply(input inst_t x);
    word_t a;
    word_t b;
    word_t addr;
    a    = m_regs[x.r.rs];
    b    = m_regs[x.r.rt];
    addr = a + sext(x.i.imm);
    case (x.r.op1)
      OP1_ALUR: begin
        case (x.r.op2)
          OP2_EQ:   m_regs[x.r.rd] = word_t'(a == b);
          OP2_LT:   m_regs[x.r.rd] = word_t'($signed(a) < $signed(b));
          OP2_LE:   m_regs[x.r.rd] = word_t'($signed(a) <= $signed(b));
          OP2_NE:   m_regs[x.r.rd] = word_t'(a != b);
          OP2_ADD:  m_regs[x.r.rd] = a + b;
          OP2_AND:  m_regs[x.r.rd] = a & b;
          OP2_OR:   m_regs[x.r.rd] = a | b;
          OP2_XOR:  m_regs[x.r.rd] = a ^ b;
          OP2_SUB:  m_regs[x.r.rd] = a - b;
          OP2_NXOR: m_regs[x.r.rd] = ~(a ^ b);
          OP2_RSHF: m_regs[x.r.rd] = $signed(a) >>> b[4:0];
          OP2_LSHF: m_regs[x.r.rd] = a << b[4:0];
          default:  ; // Unknown op2 is a no-op
        endcase
      end
      OP1_LW:   m_regs[x.i.rt] = load_ref(addr);
      OP1_SW:   store_ref(addr, b);
      OP1_ADDI: m_regs[x.i.rt] = addr;
      OP1_ANDI: m_regs[x.i.rt] = a & sext(x.i.imm);
      OP1_ORI:  m_regs[x.i.rt] = a | sext(x.i.imm);
      OP1_XORI: m_regs[x.i.rt] = a ^ sext(x.i.imm);
      default:  ;
    endcase
  endtask

  task automatic check_val(input string name, input word_t exp, input word_t got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_outputs();
    check_val("hex_value", word_t'(m_hex), word_t'(hex_value));
    check_val("ledr", word_t'(m_ledr), word_t'(ledr));
  endtask

  // Called on a falling edge
  task automatic drive(input inst_t x);
    inst_valid = 1'b1;
    inst       = x;
    model_apply(x);
  endtask

  // One instruction every 4 cycles
  // Outputs checked once a store has landed
  task automatic send(input inst_t x);
    @(negedge clk);
    drive(x);
    @(negedge clk);
    inst_valid = 1'b0;
    repeat (2) @(negedge clk);
    check_outputs();
  endtask

  task automatic begin_test();
    t_checks = checks;
    t_errors = errors;
  endtask

  task automatic end_test(input string name);
    $display("%s done: %0d checks, %0d mismatches", name, checks - t_checks,
             errors - t_errors);
  endtask

  initial begin
    logic [7:0]               idx;
    logic [`CPU_LEDRBITS-1:0] old_ledr;
    int                       asrt_fails;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    key        = '0;
    sw         = '0;
    m_hex      = '0;
    m_ledr     = '0;
    for (int i = 0; i < 16; i++)
      m_regs[i] = '0;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    begin_test();
    check_outputs();
    end_test("reset");

    // r0 stays zero so it can serve as the base register
    begin_test();
    repeat (2) begin
      for (int k = 0; k < 4; k++) begin
        send(i_inst(OP1_ADDI, rand16(), 4'd0, 4'd1));
        send(i_inst(imm_ops[k], rand16(), 4'd1, 4'd2));
        send(i_inst(OP1_SW, 16'hF000, 4'd0, 4'd2));
      end
    end
    end_test("immediate ALU");

    begin_test();
    send(i_inst(OP1_ADDI, rand16(), 4'd0, 4'd3));
    send(i_inst(OP1_ADDI, rand16(), 4'd0, 4'd4));
    for (int k = 0; k < 12; k++) begin
      send(r_inst(alu_ops[k], 4'd5, 4'd3, 4'd4));
      send(i_inst(OP1_SW, 16'hF000, 4'd0, 4'd5));
    end
    end_test("register ALU");

    begin_test();
    for (int k = 0; k < 4; k++) begin
      idx = 8'(k * 53 + 7);
      send(i_inst(OP1_ADDI, rand16(), 4'd0, 4'd6));
      send(i_inst(OP1_SW, {6'd0, idx, 2'b00}, 4'd0, 4'd6));
    end
    for (int k = 0; k < 4; k++) begin
      idx = 8'(k * 53 + 7);
      send(i_inst(OP1_LW, {6'd0, idx, 2'b00}, 4'd0, 4'd7));
      send(i_inst(OP1_SW, 16'hF020, 4'd0, 4'd7));
    end
    end_test("data memory");

    begin_test();
    key = 4'($random(seed));
    sw  = 10'($random(seed));
    send(i_inst(OP1_LW, 16'hF080, 4'd0, 4'd8));
    send(i_inst(OP1_SW, 16'hF000, 4'd0, 4'd8));
    send(i_inst(OP1_LW, 16'hF090, 4'd0, 4'd9));
    send(i_inst(OP1_SW, 16'hF000, 4'd0, 4'd9));
    end_test("input reads");

    begin_test();
    send(i_inst(OP1_ADDI, rand16(), 4'd0, 4'd10));
    send(i_inst(OP1_ADDI, rand16(), 4'd0, 4'd11));
    send(i_inst(OP1_ADDI, rand16(), 4'd0, 4'd12));
    old_ledr = m_ledr;
    @(negedge clk);
    drive(i_inst(OP1_SW, 16'hF000, 4'd0, 4'd10));
    @(negedge clk);
    drive(i_inst(OP1_SW, 16'hF020, 4'd0, 4'd11));
    @(negedge clk);
    drive(r_inst(8'hFF, 4'd12, 4'd10, 4'd11)); // Unknown op2 aimed at r12
    @(negedge clk);
    inst_valid = 1'b0;
    check_val("hex_value", word_t'(m_hex), word_t'(hex_value));
    check_val("ledr", word_t'(old_ledr), word_t'(ledr)); // LEDR store one cycle behind
    @(negedge clk);
    check_val("ledr", word_t'(m_ledr), word_t'(ledr));
    @(negedge clk); // Any stray r12 write lands before the read below
    send(i_inst(OP1_SW, 16'hF000, 4'd0, 4'd12));
    end_test("back-to-back stores");

    asrt_fails = UUT.u_assertions.fail_count;
    $display("%0d checks, %0d mismatches, %0d assertion failures", checks, errors,
             asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/cpu_top_assertions.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module cpu_top_assertions (
  input wire                      clk,
  input wire                      reset,
  input wire                      inst_valid,
  input wire cpu_isa_pkg::inst_t  inst,
  input wire cpu_isa_pkg::word_t  rs_value,
  input wire cpu_pipe_pkg::wb_t   wb,
  input wire [`CPU_HEXBITS-1:0]   hex_value,
  input wire [`CPU_LEDRBITS-1:0]  ledr
);

  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;

  int    fail_count = 0;
  word_t store_addr;
  logic  store_hex;
  logic  store_ledr;

  // Address of a store as seen at its strobe
  assign store_addr = rs_value +
    {{(`CPU_DBITS-`CPU_IMMBITS){inst.i.imm[`CPU_IMMBITS-1]}}, inst.i.imm};
  assign store_hex  = inst_valid && inst.r.op1 == OP1_SW && store_addr == `CPU_ADDR_HEX;
  assign store_ledr = inst_valid && inst.r.op1 == OP1_SW && store_addr == `CPU_ADDR_LEDR;

  // Output loads at edge 2, so the sampled change shows at edge 3
  hex_timing: assert property (@(posedge clk) disable iff (reset)
    $changed(hex_value) |-> $past(store_hex, 3))
    else begin
      fail_count++;
      $error("hex_value changed without a HEX store strobed two cycles earlier");
    end

  ledr_timing: assert property (@(posedge clk) disable iff (reset)
    $changed(ledr) |-> $past(store_ledr, 3))
    else begin
      fail_count++;
      $error("ledr changed without a LEDR store strobed two cycles earlier");
    end

  reset_outputs: assert property (@(posedge clk)
    reset |-> hex_value == '0 && ledr == '0)
    else begin
      fail_count++;
      $error("outputs not zero during reset");
    end

  bubble_no_write: assert property (@(posedge clk) disable iff (reset)
    !inst_valid |-> ##3 !wb.we)
    else begin
      fail_count++;
      $error("register write raised by a bubble");
    end

  inst_known: assert property (@(posedge clk) disable iff (reset)
    inst_valid |-> !$isunknown(inst))
    else begin
      fail_count++;
      $error("instruction has unknown bits while strobed");
    end

endmodule

bind cpu_top cpu_top_assertions u_assertions (
  .clk        (clk),
  .reset      (reset),
  .inst_valid (inst_valid),
  .inst       (inst),
  .rs_value   (rs_value),
  .wb         (wb),
  .hex_value  (hex_value),
  .ledr       (ledr)
);

`default_nettype wire

// File: logic/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module cpu_top (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     inst_valid,
  input  wire cpu_isa_pkg::inst_t inst,
  input  wire [`CPU_KEYBITS-1:0]  key,
  input  wire [`CPU_SWBITS-1:0]   sw,
  output logic [`CPU_HEXBITS-1:0]  hex_value,
  output logic [`CPU_LEDRBITS-1:0] ledr
);

  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;

  regno_t  rs;
  regno_t  rt;
  word_t   rs_value;
  word_t   rt_value;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  wb_t     wb;

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs_value   (rs_value),
    .rt_value   (rt_value),
    .rs         (rs),
    .rt         (rt),
    .id_ex      (id_ex)
  );

  reg_file u_regs (
    .clk      (clk),
    .reset    (reset),
    .rs       (rs),
    .rt       (rt),
    .wb       (wb),
    .rs_value (rs_value),
    .rt_value (rt_value)
  );

  exec_stage u_exec (
    .clk    (clk),
    .reset  (reset),
    .id_ex  (id_ex),
    .ex_mem (ex_mem)
  );

  mem_stage u_mem (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .key       (key),
    .sw        (sw),
    .wb        (wb),
    .hex_value (hex_value),
    .ledr      (ledr)
  );

endmodule

`default_nettype wire

// File: logic/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module mem_stage (
  input  wire                         clk,
  input  wire                         reset,
  input  wire cpu_pipe_pkg::ex_mem_t  ex_mem,
  input  wire [`CPU_KEYBITS-1:0]      key,
  input  wire [`CPU_SWBITS-1:0]       sw,
  output cpu_pipe_pkg::wb_t           wb,
  output logic [`CPU_HEXBITS-1:0]     hex_value,
  output logic [`CPU_LEDRBITS-1:0]    ledr
);

  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;

  localparam int DMEM_ABITS = $clog2(`CPU_DMEM_WORDS);

  word_t                 dmem [`CPU_DMEM_WORDS];
  word_t                 addr;
  logic [DMEM_ABITS-1:0] dmem_idx;
  logic                  store_en;
  logic                  hit_hex;
  logic                  hit_ledr;
  word_t                 load_data;
  wb_t                   wb_d;

  assign addr     = ex_mem.alu_result;
  assign dmem_idx = addr[DMEM_ABITS+1:2]; // Word address
  assign store_en = ex_mem.valid & ex_mem.mem_we;
  assign hit_hex  = (addr == `CPU_ADDR_HEX);
  assign hit_ledr = (addr == `CPU_ADDR_LEDR);

  always_ff @(posedge clk) begin
    if (store_en && !hit_hex && !hit_ledr)
      dmem[dmem_idx] <= ex_mem.store_data;
  end

  // Output registers
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex_value <= '0;
      ledr      <= '0;
    end else if (store_en) begin
      if (hit_hex)
        hex_value <= ex_mem.store_data[`CPU_HEXBITS-1:0];
      if (hit_ledr)
        ledr <= ex_mem.store_data[`CPU_LEDRBITS-1:0];
    end
  end

  // Keys are active low on the board
  always_comb begin
    if (addr == `CPU_ADDR_KEY)
      load_data = {{(`CPU_DBITS-`CPU_KEYBITS){1'b0}}, ~key};
    else if (addr == `CPU_ADDR_SW)
      load_data = {{(`CPU_DBITS-`CPU_SWBITS){1'b0}}, sw};
    else
      load_data = dmem[dmem_idx];
  end

  always_comb begin
    wb_d.we    = ex_mem.valid & ex_mem.reg_we;
    wb_d.regno = ex_mem.dst;
    if (ex_mem.wr_src == WR_MEM && ex_mem.mem_re)
      wb_d.data = load_data;
    else
      wb_d.data = ex_mem.alu_result;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      wb <= '0;
    else
      wb <= wb_d;
  end

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
  input  wire                  clk,
  input  wire                  reset,
  input  wire cpu_pipe_pkg::id_ex_t id_ex,
  output cpu_pipe_pkg::ex_mem_t ex_mem
);

  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  word_t      alu_out;
  ex_mem_t    ex_mem_d;

  assign op_a  = id_ex.rs_value;
  assign op_b  = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.rt_value;
  assign shamt = op_b[4:0];

  always_comb begin
    case (id_ex.op1)
      OP1_ALUR: begin
        case (id_ex.op2)
          OP2_EQ:   alu_out = word_t'(op_a == op_b);
          OP2_LT:   alu_out = word_t'($signed(op_a) < $signed(op_b));
          OP2_LE:   alu_out = word_t'($signed(op_a) <= $signed(op_b));
          OP2_NE:   alu_out = word_t'(op_a != op_b);
          OP2_ADD:  alu_out = op_a + op_b;
          OP2_AND:  alu_out = op_a & op_b;
          OP2_OR:   alu_out = op_a | op_b;
          OP2_XOR:  alu_out = op_a ^ op_b;
          OP2_SUB:  alu_out = op_a - op_b;
          OP2_NXOR: alu_out = op_a ~^ op_b;
          OP2_RSHF: alu_out = $signed(op_a) >>> shamt; // Sign fill
          OP2_LSHF: alu_out = op_a << shamt;
          default:  alu_out = '0;
        endcase
      end
      OP1_LW, OP1_SW, OP1_ADDI: alu_out = op_a + op_b; // Address or sum
      OP1_ANDI: alu_out = op_a & op_b;
      OP1_ORI:  alu_out = op_a | op_b;
      OP1_XORI: alu_out = op_a ^ op_b;
      default:  alu_out = '0;
    endcase
  end

  always_comb begin
    ex_mem_d.valid      = id_ex.valid;
    ex_mem_d.alu_result = alu_out;
    ex_mem_d.store_data = id_ex.rt_value;
    ex_mem_d.dst        = id_ex.ctrl.dst_is_rd ? id_ex.rd : id_ex.rt;
    // Bubbles carry no enables forward
    ex_mem_d.mem_we     = id_ex.valid & id_ex.ctrl.mem_we;
    ex_mem_d.mem_re     = id_ex.valid & id_ex.ctrl.mem_re;
    ex_mem_d.reg_we     = id_ex.valid & id_ex.ctrl.reg_we;
    ex_mem_d.wr_src     = id_ex.ctrl.wr_src;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      ex_mem <= '0;
    else
      ex_mem <= ex_mem_d;
  end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module reg_file (
  input  wire                 clk,
  input  wire                 reset,
  input  wire cpu_isa_pkg::regno_t rs,
  input  wire cpu_isa_pkg::regno_t rt,
  input  wire cpu_pipe_pkg::wb_t   wb,
  output cpu_isa_pkg::word_t  rs_value,
  output cpu_isa_pkg::word_t  rt_value
);

  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;

  localparam int REG_WORDS = 1 << `CPU_REGNOBITS;

  word_t regs [REG_WORDS];

  // r0 is not hardwired
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < REG_WORDS; i++)
        regs[i] <= '0;
    end else if (wb.we) begin
      regs[wb.regno] <= wb.data;
    end
  end

  assign rs_value = regs[rs];
  assign rt_value = regs[rt];

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module decode_stage (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 inst_valid,
  input  wire cpu_isa_pkg::inst_t inst,
  input  wire cpu_isa_pkg::word_t rs_value,
  input  wire cpu_isa_pkg::word_t rt_value,
  output cpu_isa_pkg::regno_t rs,
  output cpu_isa_pkg::regno_t rt,
  output cpu_pipe_pkg::id_ex_t id_ex
);

  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;

  ctrl_t  ctrl;
  logic   op2_known;
  id_ex_t id_ex_d;

  // Register file reads are combinational
  assign rs = inst.r.rs;
  assign rt = inst.r.rt;

  always_comb begin
    case (inst.r.op2)
      OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND, OP2_OR,
      OP2_XOR, OP2_SUB, OP2_NXOR, OP2_RSHF, OP2_LSHF: op2_known = 1'b1;
      default: op2_known = 1'b0;
    endcase
  end

  // Anything unrecognised stays all off
  always_comb begin
    ctrl = '0;
    case (inst.r.op1)
      OP1_ALUR: begin
        ctrl.reg_we    = op2_known; // Bad op2 turns into a no-op here
        ctrl.wr_src    = WR_ALU;
        ctrl.dst_is_rd = 1'b1;
      end
      OP1_LW: begin
        ctrl.use_imm = 1'b1;
        ctrl.mem_re  = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.wr_src  = WR_MEM;
      end
      OP1_SW: begin
        ctrl.use_imm = 1'b1;
        ctrl.mem_we  = 1'b1;
      end
      OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI: begin
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.wr_src  = WR_ALU;
      end
      default: ctrl = '0;
    endcase
  end

  always_comb begin
    id_ex_d.valid    = inst_valid;
    id_ex_d.op1      = inst.r.op1;
    id_ex_d.op2      = inst.r.op2;
    id_ex_d.rs_value = rs_value;
    id_ex_d.rt_value = rt_value;
    id_ex_d.imm      = {{(`CPU_DBITS-`CPU_IMMBITS){inst.i.imm[`CPU_IMMBITS-1]}}, inst.i.imm};
    id_ex_d.rt       = inst.r.rt;
    id_ex_d.rd       = inst.r.rd;
    id_ex_d.ctrl     = ctrl;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      id_ex <= '0;
    else
      id_ex <= id_ex_d;
  end

endmodule

`default_nettype wire

// File: logic/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

  import cpu_isa_pkg::*;

  // Decode to execute
  typedef struct packed {
    logic   valid;
    op1_t   op1;
    op2_t   op2;
    word_t  rs_value;
    word_t  rt_value;
    word_t  imm;      // Already sign-extended
    regno_t rt;
    regno_t rd;
    ctrl_t  ctrl;
  } id_ex_t;

  // Execute to memory
  typedef struct packed {
    logic    valid;
    word_t   alu_result;
    word_t   store_data;
    regno_t  dst;
    logic    mem_we;
    logic    mem_re;
    logic    reg_we;
    wr_src_t wr_src;
  } ex_mem_t;

  // Memory to register file
  typedef struct packed {
    logic   we;
    regno_t regno;
    word_t  data;
  } wb_t;

endpackage

`default_nettype wire

// File: logic/cpu_isa_pkg.sv
`default_nettype none
`include "cpu_cfg.svh"

package cpu_isa_pkg;

  typedef logic [`CPU_DBITS-1:0]     word_t;
  typedef logic [`CPU_REGNOBITS-1:0] regno_t;

  typedef enum logic [5:0] {
    OP1_ALUR = 6'b000000,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_t;

  // Secondary opcode, only meaningful under ALUR
  typedef enum logic [7:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,
    OP2_LSHF = 8'b00110001
  } op2_t;

  typedef struct packed {
    op1_t       op1;    // 31:26
    op2_t       op2;    // 25:18
    logic [5:0] unused; // 17:12
    regno_t     rd;     // 11:8
    regno_t     rs;     // 7:4
    regno_t     rt;     // 3:0
  } inst_r_t;

  // Immediate sits on top of op2 low bits and rd
  typedef struct packed {
    op1_t                   op1;
    logic [1:0]             unused;
    logic [`CPU_IMMBITS-1:0] imm;   // 23:8
    regno_t                 rs;
    regno_t                 rt;
  } inst_i_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_t;

  typedef enum logic {
    WR_MEM = 1'b0,
    WR_ALU = 1'b1
  } wr_src_t;

  typedef struct packed {
    logic    use_imm;   // Second ALU operand is the immediate
    logic    mem_we;
    logic    mem_re;
    logic    reg_we;
    wr_src_t wr_src;
    logic    dst_is_rd; // Else rt is the destination
  } ctrl_t;

endpackage

`default_nettype wire

// File: logic/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath widths
`define CPU_DBITS      32
`define CPU_REGNOBITS  4
`define CPU_IMMBITS    16
`define CPU_DMEM_WORDS 256

// Memory-mapped I/O
`define CPU_ADDR_HEX   32'hFFFFF000
`define CPU_ADDR_LEDR  32'hFFFFF020
`define CPU_ADDR_KEY   32'hFFFFF080
`define CPU_ADDR_SW    32'hFFFFF090
`define CPU_HEXBITS    24
`define CPU_LEDRBITS   10
`define CPU_KEYBITS    4
`define CPU_SWBITS     10

`endif
